/* filelist.f */
+incdir+logic
logic/bldc_pkg.sv
logic/duty_if.sv
logic/commutation_angle.sv
logic/shift_add_multiplier.sv
logic/duty_sequencer.sv
logic/pwm_bank.sv
logic/bldc_drive.sv
tb/bldc_drive_asserts.sv
tb/bldc_drive_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module bldc_drive_tb &&
    ./obj_dir/Vbldc_drive_tb | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

/* tb/bldc_drive_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bldc_defs.svh"

module bldc_drive_tb;

    localparam int PERIOD_CLKS  = `BLDC_PWM_PERIOD * `BLDC_TICK_DIV;
    localparam int SETTLE_CLKS  = 3 * PERIOD_CLKS;
    localparam int NUM_TESTS    = 14;
    localparam int TIMEOUT_CLKS = NUM_TESTS * 4 * PERIOD_CLKS + 1000;

    // Offset binary sine, floor(127 + 127 * sin(2*pi*i/64)).
    localparam int SINE_REF [`BLDC_TABLE_LEN] = '{
        127, 139, 151, 163, 175, 186, 197, 207, 216, 225, 232, 239, 244, 248, 251, 253,
        254, 253, 251, 248, 244, 239, 232, 225, 216, 207, 197, 186, 175, 163, 151, 139,
        127, 114, 102, 90,  78,  67,  56,  46,  37,  28,  21,  14,  9,   5,   2,   0,
        0,   0,   2,   5,   9,   14,  21,  28,  37,  46,  56,  67,  78,  90,  102, 114
    };

    logic               clk;
    logic               rst;
    logic               enable;
    logic               testmode;
    logic signed [15:0] velocity;
    logic signed [7:0]  offset;
    logic [7:0]         torque;
    logic [15:0]        feedback;
    logic               en;
    logic               u;
    logic               v;
    logic               w;

    logic [15:0] lfsr;
    int          error_count;
    int          check_count;
    int          cycle_count;
    string       phase_names [3] = '{"u", "v", "w"};

    bldc_drive i_bldc_drive (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .testmode (testmode),
        .velocity (velocity),
        .offset   (offset),
        .torque   (torque),
        .feedback (feedback),
        .en       (en),
        .u        (u),
        .v        (v),
        .w        (w)
    );

    bind bldc_drive bldc_drive_asserts i_asserts (
        .clk    (clk),
        .rst    (rst),
        .update (duty_bus.update),
        .load   (i_duty_sequencer.i_multiplier.load),
        .valid  (i_duty_sequencer.i_multiplier.valid),
        .enable (enable),
        .u      (u),
        .v      (v),
        .w      (w)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CLKS) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ============================================================
    // Stimulus source and reference model
    // ============================================================
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    // High ticks per period for one phase.
    function automatic int expected_ticks(input logic tm, input int vel, input int offs,
                                          input int torq, input int fb, input int phase);
        int mag;
        int ang;
        int duty;
        mag = (vel < 0) ? -vel : vel;
        if (mag > 255) begin
            mag = 255;
        end
        if (tm) begin
            ang = offs;
        end else if (vel < 0) begin
            ang = (fb >> `BLDC_FB_SHIFT) + offs + torq;
        end else begin
            ang = (fb >> `BLDC_FB_SHIFT) + offs - torq;
        end
        if (phase == 1) begin
            ang = ang + `BLDC_PHASE_V;
        end else if (phase == 2) begin
            ang = ang + `BLDC_PHASE_W;
        end
        ang  = ang & (`BLDC_TABLE_LEN - 1);
        duty = SINE_REF[ang] * mag / 100;
        if (duty > `BLDC_PWM_PERIOD) begin
            duty = `BLDC_PWM_PERIOD;
        end
        return duty;
    endfunction

    // ============================================================
    // Drive and check tasks
    // ============================================================
    task automatic apply_inputs(input logic tm, input int vel, input int offs,
                                input int torq, input int fb);
        @(posedge clk);
        testmode <= tm;
        velocity <= 16'(vel);
        offset   <= 8'(offs);
        torque   <= 8'(torq);
        feedback <= 16'(fb);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic got);
        check_count++;
        if (got !== expected) begin
            $display("ERR %0t: %s expected %0b got %0b", $time, name, expected, got);
            error_count++;
        end
    endtask

    task automatic check_outputs_low(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_bit("en", 1'b0, en);
            check_bit("u", 1'b0, u);
            check_bit("v", 1'b0, v);
            check_bit("w", 1'b0, w);
        end
    endtask

    // Any full period window holds each pulse exactly once.
    task automatic check_widths(input string name, input logic tm, input int vel,
                                input int offs, input int torq, input int fb);
        int high_cnt [3];
        int exp_ticks;
        int got_ticks;
        int errors_before;
        errors_before = error_count;
        apply_inputs(tm, vel, offs, torq, fb);
        repeat (SETTLE_CLKS) @(posedge clk);
        high_cnt = '{0, 0, 0};
        repeat (PERIOD_CLKS) begin
            @(posedge clk);
            check_bit("en", 1'b1, en);
            high_cnt[0] += int'(u);
            high_cnt[1] += int'(v);
            high_cnt[2] += int'(w);
        end
        for (int p = 0; p < 3; p++) begin
            exp_ticks = expected_ticks(tm, vel, offs, torq, fb, p);
            got_ticks = high_cnt[p] / `BLDC_TICK_DIV;
            check_count++;
            if (got_ticks != exp_ticks) begin
                $display("ERR %0t: %s expected %0d got %0d", $time, phase_names[p],
                         exp_ticks, got_ticks);
                error_count++;
            end
        end
        $display("%s: %s", name, (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int vel;
        int offs;
        int torq;
        int fb;
        int errors_before;
        lfsr        = 16'd34911;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        rst         = 1'b1;
        enable      = 1'b0;
        testmode    = 1'b0;
        velocity    = '0;
        offset      = '0;
        torque      = '0;
        feedback    = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        errors_before = error_count;
        check_outputs_low(20);
        @(posedge clk);
        enable <= 1'b1;
        @(posedge clk);
        check_bit("en", 1'b0, en);
        @(posedge clk);
        check_bit("en", 1'b1, en);
        $display("reset and enable: %s", (error_count == errors_before) ? "ok" : "FAILED");

        check_widths("test mode offset 0", 1'b1, 128, 0, 0, 0);
        check_widths("test mode offset 9", 1'b1, 128, 9, 0, 0);
        check_widths("test mode offset 30", 1'b1, 128, 30, 0, 0);
        check_widths("test mode offset -12", 1'b1, 128, -12, 0, 0);

        for (int round = 0; round < 2; round++) begin
            vel  = 20 + rand_bits(7);
            fb   = rand_bits(16);
            offs = rand_bits(8);
            if (offs > 127) begin
                offs = offs - 256;
            end
            torq = rand_bits(8);
            check_widths("feedback positive velocity", 1'b0, vel, offs, torq, fb);
            check_widths("feedback negative velocity", 1'b0, -vel, offs, torq, fb);
        end

        check_widths("zero velocity", 1'b0, 0, 5, 7, 4660);
        check_widths("saturated speed feedback", 1'b0, -32768, rand_bits(6), 3, rand_bits(16));
        check_widths("saturated speed test mode", 1'b1, 1000, 16, 0, 0);

        // Drop enable in the middle of a period while u is held high, then bring it back.
        errors_before = error_count;
        repeat (200) @(posedge clk);
        enable <= 1'b0;
        @(posedge clk);
        check_outputs_low(100);
        enable <= 1'b1;
        $display("enable drop: %s", (error_count == errors_before) ? "ok" : "FAILED");
        check_widths("enable restored", 1'b1, 200, 10, 0, 0);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/bldc_drive_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module bldc_drive_asserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic update,
    input wire logic load,
    input wire logic valid,
    input wire logic enable,
    input wire logic u,
    input wire logic v,
    input wire logic w
);

    // Duty update is a single-cycle strobe.
    update_one_cycle: assert property (
        @(posedge clk) disable iff (rst) update |=> !update
    ) else $error("duty update stayed high for more than one cycle");

    // Each multiplier load returns exactly one product two cycles later.
    valid_after_load: assert property (
        @(posedge clk) disable iff (rst) valid == $past(load, 2)
    ) else $error("multiplier valid does not follow load by two cycles");

    // Phases drop one cycle after the enable input falls.
    phases_low_when_disabled: assert property (
        @(posedge clk) disable iff (rst) !enable |=> !(u || v || w)
    ) else $error("a phase output is high while the drive is disabled");

endmodule

`default_nettype wire

/* logic/bldc_drive.sv */
`timescale 1ns/100ps
`default_nettype none

module bldc_drive (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               enable,
    input  wire logic               testmode,
    input  wire logic signed [15:0] velocity,
    input  wire logic signed [7:0]  offset,
    input  wire logic [7:0]         torque,
    input  wire logic [15:0]        feedback,
    output logic                    en,
    output logic                    u,
    output logic                    v,
    output logic                    w
);
    import bldc_pkg::*;

    speed_t speed;
    angle_t angle_u;
    angle_t angle_v;
    angle_t angle_w;

    duty_if duty_bus ();

    commutation_angle i_commutation_angle (
        .clk      (clk),
        .rst      (rst),
        .testmode (testmode),
        .velocity (velocity),
        .offset   (offset),
        .torque   (torque),
        .feedback (feedback),
        .speed    (speed),
        .angle_u  (angle_u),
        .angle_v  (angle_v),
        .angle_w  (angle_w)
    );

    duty_sequencer i_duty_sequencer (
        .clk     (clk),
        .rst     (rst),
        .speed   (speed),
        .angle_u (angle_u),
        .angle_v (angle_v),
        .angle_w (angle_w),
        .duty    (duty_bus.source)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            en <= 1'b0;
        end else begin
            en <= enable;
        end
    end

    // The bank runs from en, so the phases drop in the same cycle as en.
    pwm_bank i_pwm_bank (
        .clk    (clk),
        .rst    (rst),
        .enable (en),
        .duty   (duty_bus.sink),
        .u      (u),
        .v      (v),
        .w      (w)
    );

endmodule

`default_nettype wire

/* logic/pwm_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bldc_defs.svh"

module pwm_bank (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic enable,
    duty_if.sink      duty,
    output logic      u,
    output logic      v,
    output logic      w
);
    import bldc_pkg::*;

    localparam int                TICK_W      = $clog2(`BLDC_TICK_DIV + 1);
    localparam logic [TICK_W-1:0] TICK_LAST   = TICK_W'(`BLDC_TICK_DIV - 1);
    localparam logic [7:0]        PERIOD_LAST = 8'(`BLDC_PWM_PERIOD - 1);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic [7:0]        period_cnt;
    logic              period_end;
    duty_t             pending [3];
    duty_t             active [3];
    logic [2:0]        phase_out;

    // ============================================================
    // Tick divider and shared period counter
    // ============================================================
    assign tick       = (tick_cnt == TICK_LAST);
    assign period_end = tick && (period_cnt == PERIOD_LAST);

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            tick_cnt   <= '0;
            period_cnt <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (period_end) begin
                period_cnt <= '0;
            end else if (tick) begin
                period_cnt <= period_cnt + 8'd1;
            end
        end
    end

    // ============================================================
    // Duty latches
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '{default: '0};
            active  <= '{default: '0};
        end else begin
            if (duty.update) begin
                pending[0] <= duty.duty_u;
                pending[1] <= duty.duty_v;
                pending[2] <= duty.duty_w;
            end
            // Swap only at the period boundary so a pulse is never cut short.
            if (!enable || period_end) begin
                active <= pending;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            phase_out[i] = enable && (duty_t'(period_cnt) < active[i]);
        end
    end

    assign u = phase_out[0];
    assign v = phase_out[1];
    assign w = phase_out[2];

endmodule

`default_nettype wire

/* logic/duty_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bldc_defs.svh"

module duty_sequencer (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire bldc_pkg::speed_t speed,
    input  wire bldc_pkg::angle_t angle_u,
    input  wire bldc_pkg::angle_t angle_v,
    input  wire bldc_pkg::angle_t angle_w,
    duty_if.source                duty
);
    import bldc_pkg::*;

    localparam product_t DUTY_DIVISOR = 16'd100;

    // One full electrical turn, offset binary around 127.
    localparam sample_t SINE_TABLE [`BLDC_TABLE_LEN] = '{
        8'd127, 8'd139, 8'd151, 8'd163, 8'd175, 8'd186, 8'd197, 8'd207,
        8'd216, 8'd225, 8'd232, 8'd239, 8'd244, 8'd248, 8'd251, 8'd253,
        8'd254, 8'd253, 8'd251, 8'd248, 8'd244, 8'd239, 8'd232, 8'd225,
        8'd216, 8'd207, 8'd197, 8'd186, 8'd175, 8'd163, 8'd151, 8'd139,
        8'd127, 8'd114, 8'd102, 8'd90,  8'd78,  8'd67,  8'd56,  8'd46,
        8'd37,  8'd28,  8'd21,  8'd14,  8'd9,   8'd5,   8'd2,   8'd0,
        8'd0,   8'd0,   8'd2,   8'd5,   8'd9,   8'd14,  8'd21,  8'd28,
        8'd37,  8'd46,  8'd56,  8'd67,  8'd78,  8'd90,  8'd102, 8'd114
    };

    seq_state_t state;
    seq_state_t state_next;
    logic [1:0] arrival;
    logic       mult_load;
    angle_t     issue_angle;
    sample_t    mult_a;
    logic       mult_valid;
    product_t   mult_product;
    duty_t      scaled;

    // ============================================================
    // Round control
    // ============================================================
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                state_next = issue_u;
            end
            issue_u: begin
                state_next = issue_v;
            end
            issue_v: begin
                state_next = issue_w;
            end
            issue_w: begin
                state_next = collect;
            end
            collect: begin
                // Third product lands on the last collect cycle.
                if (mult_valid && arrival == 2'd2) begin
                    state_next = publish;
                end
            end
            publish: begin
                state_next = issue_u;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_comb begin
        mult_load   = 1'b0;
        issue_angle = angle_u;
        case (state)
            issue_u: begin
                mult_load = 1'b1;
            end
            issue_v: begin
                mult_load   = 1'b1;
                issue_angle = angle_v;
            end
            issue_w: begin
                mult_load   = 1'b1;
                issue_angle = angle_w;
            end
            default: begin
                mult_load = 1'b0;
            end
        endcase
    end

    assign mult_a = SINE_TABLE[issue_angle];

    shift_add_multiplier i_multiplier (
        .clk     (clk),
        .rst     (rst),
        .load    (mult_load),
        .a       (mult_a),
        .b       (speed),
        .valid   (mult_valid),
        .product (mult_product)
    );

    // ============================================================
    // Collect and publish
    // ============================================================
    assign scaled = duty_t'(mult_product / DUTY_DIVISOR);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            arrival     <= 2'd0;
            duty.duty_u <= '0;
            duty.duty_v <= '0;
            duty.duty_w <= '0;
        end else begin
            state <= state_next;
            if (state == publish) begin
                arrival <= 2'd0;
            end else if (mult_valid) begin
                // Products return in issue order.
                case (arrival)
                    2'd0:    duty.duty_u <= scaled;
                    2'd1:    duty.duty_v <= scaled;
                    default: duty.duty_w <= scaled;
                endcase
                arrival <= arrival + 2'd1;
            end
        end
    end

    assign duty.update = (state == publish);

endmodule

`default_nettype wire

/* logic/shift_add_multiplier.sv */
`timescale 1ns/100ps
`default_nettype none

module shift_add_multiplier (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              load,
    input  wire bldc_pkg::sample_t a,
    input  wire bldc_pkg::speed_t  b,
    output logic                   valid,
    output bldc_pkg::product_t     product
);
    import bldc_pkg::*;

    localparam int A_W = $bits(sample_t);

    product_t partial [A_W];
    product_t partial_sum;
    logic     stage1_valid;

    // Stage one: one gated, shifted copy of b per bit of a.
    always_ff @(posedge clk) begin
        for (int i = 0; i < A_W; i++) begin
            partial[i] <= a[i] ? (product_t'(b) << i) : '0;
        end
    end

    always_comb begin
        partial_sum = '0;
        for (int i = 0; i < A_W; i++) begin
            partial_sum = partial_sum + partial[i];
        end
    end

    // Stage two.
    always_ff @(posedge clk) begin
        product <= partial_sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            valid        <= 1'b0;
        end else begin
            stage1_valid <= load;
            valid        <= stage1_valid;
        end
    end

endmodule

`default_nettype wire

/* logic/commutation_angle.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bldc_defs.svh"

module commutation_angle (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                testmode,
    input  wire logic signed [15:0]  velocity,
    input  wire logic signed [7:0]   offset,
    input  wire logic [7:0]          torque,
    input  wire bldc_pkg::feedback_t feedback,
    output bldc_pkg::speed_t         speed,
    output bldc_pkg::angle_t         angle_u,
    output bldc_pkg::angle_t         angle_v,
    output bldc_pkg::angle_t         angle_w
);
    import bldc_pkg::*;

    logic        vel_neg;
    logic [15:0] vel_mag;
    speed_t      speed_next;
    angle_t      base_angle;
    angle_t      lead_angle;
    angle_t      angle_next;

    // ============================================================
    // Speed magnitude and direction
    // ============================================================
    assign vel_neg = velocity[15];
    // -32768 negates to itself, which still reads as 32768 unsigned.
    assign vel_mag = vel_neg ? 16'(-velocity) : $unsigned(velocity);
    assign speed_next = (vel_mag > 16'd255) ? 8'hFF : vel_mag[7:0];

    // ============================================================
    // Electrical angle, all sums wrap at the table length
    // ============================================================
    assign base_angle = angle_t'(feedback >> `BLDC_FB_SHIFT) + angle_t'(offset);

    // Torque lead goes against the direction of travel.
    assign lead_angle = vel_neg ? (base_angle + angle_t'(torque))
                                : (base_angle - angle_t'(torque));

    assign angle_next = testmode ? angle_t'(offset) : lead_angle;

    always_ff @(posedge clk) begin
        if (rst) begin
            speed   <= '0;
            angle_u <= '0;
            angle_v <= '0;
            angle_w <= '0;
        end else begin
            speed   <= speed_next;
            angle_u <= angle_next;
            angle_v <= angle_next + angle_t'(`BLDC_PHASE_V);
            angle_w <= angle_next + angle_t'(`BLDC_PHASE_W);
        end
    end

endmodule

`default_nettype wire

/* logic/duty_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface duty_if;
    import bldc_pkg::*;

    duty_t duty_u;
    duty_t duty_v;
    duty_t duty_w;
    // Single-cycle pulse, all three duties valid with it.
    logic  update;

    modport source (
        output duty_u,
        output duty_v,
        output duty_w,
        output update
    );

    modport sink (
        input duty_u,
        input duty_v,
        input duty_w,
        input update
    );
endinterface

`default_nettype wire

/* logic/bldc_pkg.sv */
`default_nettype none

package bldc_pkg;

    typedef logic [5:0]  angle_t;
    typedef logic [7:0]  sample_t;
    typedef logic [7:0]  speed_t;
    typedef logic [15:0] product_t;
    typedef logic [9:0]  duty_t;
    typedef logic [15:0] feedback_t;

    typedef enum logic [2:0] {
        idle,
        issue_u,
        issue_v,
        issue_w,
        collect,
        publish
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/bldc_defs.svh */
`ifndef BLDC_DEFS_SVH
`define BLDC_DEFS_SVH

// Sine table geometry.
`define BLDC_TABLE_LEN  64
`define BLDC_PHASE_V    21
`define BLDC_PHASE_W    42

// Feedback counts per table step is 2**BLDC_FB_SHIFT.
`define BLDC_FB_SHIFT   4

// PWM timing.
`define BLDC_TICK_DIV   2
`define BLDC_PWM_PERIOD 255

`endif
